/* list.f */
verilog/cpu_pkg.sv
verilog/stall_ctrl.sv
verilog/mem_req.sv
verilog/data_sram.sv
verilog/dc.sv
verilog/mem.sv
verilog/wb.sv
verilog/mem_backend.sv
test/mem_backend_assert.sv
test/tb_mem_backend.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_mem_backend
FILELIST = list.f

SRCS = $(shell cat $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

/* test/tb_mem_backend.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_backend;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 400;     // Upper bound per test
    localparam int REGION      = 256;     // Bytes used by the tests

    logic                clk;
    logic                rst;
    logic                flush_i;
    logic                stall_req_ex_i;
    logic                stall_req_dc_i;
    cpu_pkg::ex_to_dc_t  ex_bundle_i;
    logic                rf_we_o;
    cpu_pkg::reg_addr_t  rf_waddr_o;
    cpu_pkg::word_t      rf_wdata_o;
    cpu_pkg::word_t      wb_pc_o;

    cpu_pkg::mem_to_wb_t exp_q[$];
    logic [7:0]          mem_model [REGION];
    logic [31:0]         lfsr = 32'hebc9c947;
    cpu_pkg::word_t      pc_next = 32'h0000_1000;
    int                  errors = 0;
    int                  tests_done = 0;

    mem_backend #(.SRAM_ADDR_W(10)) mem_backend_i (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .stall_req_ex_i (stall_req_ex_i),
        .stall_req_dc_i (stall_req_dc_i),
        .ex_bundle_i    (ex_bundle_i),
        .rf_we_o        (rf_we_o),
        .rf_waddr_o     (rf_waddr_o),
        .rf_wdata_o     (rf_wdata_o),
        .wb_pc_o        (wb_pc_o)
    );

    always #50 clk = ~clk;

    // Taps 32 22 2 1 stepped once per bit
    function automatic cpu_pkg::word_t rand_bits(input int n);
        cpu_pkg::word_t r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic compare_word(input string what, input cpu_pkg::word_t got,
                                input cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_reg_addr(input string what, input cpu_pkg::reg_addr_t got,
                                    input cpu_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_we(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        cpu_pkg::mem_to_wb_t e;
        if (!rst && rf_we_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected register write at %0t to r%0d", $time, rf_waddr_o);
                errors++;
            end else begin
                e = exp_q.pop_front();
                compare_word("rf_wdata_o", rf_wdata_o, e.rf_wdata);
                compare_reg_addr("rf_waddr_o", rf_waddr_o, e.rf_waddr);
                compare_word("wb_pc_o", wb_pc_o, e.pc);
            end
        end
    end

    function automatic cpu_pkg::ex_to_dc_t make_op(input logic is_mem, input logic we,
        input cpu_pkg::mem_size_t size, input logic uns, input cpu_pkg::reg_addr_t rd,
        input cpu_pkg::word_t addr_or_res, input cpu_pkg::word_t sdata);
        cpu_pkg::ex_to_dc_t b;
        b               = '0;
        b.pc            = pc_next;
        b.ram_en        = is_mem;
        b.ram_we        = is_mem && we;
        b.size          = size;
        b.load_unsigned = uns;
        b.sel_rf_res    = is_mem && !we;
        b.rf_we         = !(is_mem && we);
        b.rf_waddr      = rd;
        b.alu_result    = addr_or_res;
        b.store_data    = sdata;
        pc_next         = pc_next + 4;
        return b;
    endfunction

    // Reference model of an accepted instruction
    task automatic model_accept(input cpu_pkg::ex_to_dc_t b);
        cpu_pkg::mem_to_wb_t e;
        cpu_pkg::word_t      w;
        cpu_pkg::word_t      v;
        int                  a;
        a = int'(b.alu_result[7:0]);
        if (b.ram_en && b.ram_we) begin
            case (b.size)
                cpu_pkg::SIZE_BYTE: mem_model[a] = b.store_data[7:0];
                cpu_pkg::SIZE_HALF: begin
                    mem_model[a & ~1]     = b.store_data[7:0];
                    mem_model[(a & ~1)+1] = b.store_data[15:8];
                end
                default: for (int i = 0; i < 4; i++)
                    mem_model[(a & ~3)+i] = b.store_data[8*i +: 8];
            endcase
        end
        for (int i = 0; i < 4; i++) w[8*i +: 8] = mem_model[(a & ~3)+i];
        case (b.size)
            cpu_pkg::SIZE_BYTE: begin
                v = {24'b0, mem_model[a]};
                if (!b.load_unsigned) v = {{24{v[7]}}, v[7:0]};
            end
            cpu_pkg::SIZE_HALF: begin
                v = {16'b0, mem_model[(a & ~1)+1], mem_model[a & ~1]};
                if (!b.load_unsigned) v = {{16{v[15]}}, v[15:0]};
            end
            default: v = w;
        endcase
        if (b.rf_we && b.rf_waddr != 5'd0) begin
            e.pc       = b.pc;
            e.rf_we    = 1'b1;
            e.rf_waddr = b.rf_waddr;
            e.rf_wdata = b.sel_rf_res ? v : b.alu_result;
            exp_q.push_back(e);
        end
    endtask

    // Starts at a falling edge and holds the input through n stalled cycles
    task automatic send(input cpu_pkg::ex_to_dc_t b, input int n, input logic on_dc);
        ex_bundle_i    = b;
        stall_req_dc_i = (n > 0) && on_dc;
        stall_req_ex_i = (n > 0) && !on_dc;
        repeat (n) @(negedge clk);
        stall_req_dc_i = 1'b0;
        stall_req_ex_i = 1'b0;
        model_accept(b);
        @(negedge clk);
        ex_bundle_i = '0;
    endtask

    task automatic drain(input string name, input int err_start);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Test %s lost %0d expected register writes", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (2) @(negedge clk);
        tests_done++;
        $display("Test %s finished with %0d errors", name, errors - err_start);
    endtask

    task automatic alu_pass_test();
        int e0;
        e0 = errors;
        send(make_op(0, 0, 0, 0, 5'd2, rand_bits(32), 0), 0, 0);
        @(negedge clk);
        compare_we("rf_we_o after two edges", rf_we_o, 1'b0);
        @(negedge clk);
        compare_we("rf_we_o after three edges", rf_we_o, 1'b1);
        for (int i = 0; i < 20; i++)
            send(make_op(0, 0, 0, 0, cpu_pkg::reg_addr_t'(rand_bits(5)), rand_bits(32), 0),
                 0, 0);
        drain("alu_pass", e0);
    endtask

    task automatic word_rw_test();
        int e0;
        cpu_pkg::word_t a;
        e0 = errors;
        for (int i = 0; i < REGION / 4; i++)
            send(make_op(1, 1, cpu_pkg::SIZE_WORD, 0, 0, i * 4, rand_bits(32)), 0, 0);
        for (int i = 0; i < 20; i++) begin
            a = rand_bits(6) << 2;
            send(make_op(1, 1, cpu_pkg::SIZE_WORD, 0, 0, a, rand_bits(32)), 0, 0);
            send(make_op(1, 0, cpu_pkg::SIZE_WORD, 0, cpu_pkg::reg_addr_t'(rand_bits(5)),
                         a, 0), 0, 0);
            send(make_op(1, 0, cpu_pkg::SIZE_WORD, 0, 5'd7, rand_bits(6) << 2, 0), 0, 0);
        end
        drain("word_rw", e0);
    endtask

    task automatic sub_word_test();
        int e0;
        cpu_pkg::word_t base;
        e0 = errors;
        for (int lane = 0; lane < 4; lane++) begin
            base = rand_bits(6) << 2;
            send(make_op(1, 1, cpu_pkg::SIZE_BYTE, 0, 0, base + lane, rand_bits(8)), 0, 0);
            for (int u = 0; u < 2; u++) begin
                send(make_op(1, 0, cpu_pkg::SIZE_BYTE, u == 1, 5'd3, base + lane, 0), 0, 0);
                send(make_op(1, 0, cpu_pkg::SIZE_WORD, u == 1, 5'd4, base, 0), 0, 0);
            end
            if (lane % 2 == 0) begin
                send(make_op(1, 1, cpu_pkg::SIZE_HALF, 0, 0, base + lane, rand_bits(16)), 0, 0);
                send(make_op(1, 0, cpu_pkg::SIZE_HALF, 0, 5'd5, base + lane, 0), 0, 0);
                send(make_op(1, 0, cpu_pkg::SIZE_HALF, 1, 5'd6, base + lane, 0), 0, 0);
            end
        end
        drain("sub_word", e0);
    endtask

    task automatic stall_test();
        int e0;
        cpu_pkg::word_t kind;
        cpu_pkg::ex_to_dc_t b;
        e0 = errors;
        for (int i = 0; i < 30; i++) begin
            kind = rand_bits(2);
            if (kind == 0)
                b = make_op(1, 1, cpu_pkg::SIZE_WORD, 0, 0, rand_bits(6) << 2, rand_bits(32));
            else if (kind == 1)
                b = make_op(1, 0, cpu_pkg::SIZE_WORD, 0, cpu_pkg::reg_addr_t'(rand_bits(5)),
                            rand_bits(6) << 2, 0);
            else
                b = make_op(0, 0, 0, 0, cpu_pkg::reg_addr_t'(rand_bits(5)), rand_bits(32), 0);
            send(b, int'(rand_bits(2)), rand_bits(1) != 0);
        end
        drain("stall", e0);
    endtask

    task automatic flush_test();
        int e0;
        cpu_pkg::word_t a;
        e0 = errors;
        a = rand_bits(6) << 2;
        ex_bundle_i = make_op(0, 0, 0, 0, 5'd9, rand_bits(32), 0);   // Dropped by the flush
        @(negedge clk);
        ex_bundle_i = make_op(0, 0, 0, 0, 5'd10, rand_bits(32), 0);
        @(negedge clk);
        ex_bundle_i = make_op(1, 1, cpu_pkg::SIZE_WORD, 0, 0, a, rand_bits(32));
        flush_i     = 1'b1;
        @(negedge clk);
        flush_i     = 1'b0;
        ex_bundle_i = '0;
        compare_we("rf_we_o after flush", rf_we_o, 1'b0);
        send(make_op(1, 0, cpu_pkg::SIZE_WORD, 0, 5'd11, a, 0), 0, 0);
        send(make_op(0, 0, 0, 0, 5'd12, rand_bits(32), 0), 0, 0);
        drain("flush", e0);
    endtask

    task automatic reg_zero_test();
        int e0;
        e0 = errors;
        send(make_op(0, 0, 0, 0, 5'd0, rand_bits(32), 0), 0, 0);
        repeat (2) @(negedge clk);
        compare_we("rf_we_o for r0", rf_we_o, 1'b0);
        send(make_op(1, 0, cpu_pkg::SIZE_WORD, 0, 5'd0, 32'h10, 0), 0, 0);
        send(make_op(0, 0, 0, 0, 5'd1, rand_bits(32), 0), 0, 0);
        drain("reg_zero", e0);
    endtask

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 100 + 2000);
        $display("Watchdog expired before the tests completed");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        flush_i        = 1'b0;
        stall_req_ex_i = 1'b0;
        stall_req_dc_i = 1'b0;
        ex_bundle_i    = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        alu_pass_test();
        word_rw_test();
        sub_word_test();
        stall_test();
        flush_test();
        reg_zero_test();
        $display("Tests run %0d, errors %0d", tests_done, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/mem_backend_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_backend_assert (
    input wire                     clk,
    input wire                     rst,
    input wire                     flush_i,
    input wire                     sram_en_i,
    input wire cpu_pkg::byte_en_t  sram_wen_i,
    input wire cpu_pkg::stall_t    stall_i,
    input wire logic [15:0]        issue_cnt_i,
    input wire                     dc_ram_en_i,
    input wire                     rf_we_i,
    input wire cpu_pkg::reg_addr_t rf_waddr_i
);

    wen_needs_en: assert property (@(posedge clk) disable iff (rst)
        sram_wen_i != 4'b0000 |-> sram_en_i)
        else $error("SRAM byte write without enable");

    flush_clears_we: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !rf_we_i)
        else $error("Register write one edge after flush");

    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        !(rf_we_i && rf_waddr_i == 5'd0))
        else $error("Register write aimed at r0");

    // Count moves exactly when a memory instruction newly enters dc
    req_per_mem_op: assert property (@(posedge clk) disable iff (rst)
        (issue_cnt_i != $past(issue_cnt_i))
            == ($past(stall_i[cpu_pkg::STG_EX] == cpu_pkg::NO_STOP) && dc_ram_en_i))
        else $error("SRAM request count out of step with memory instructions in dc");

endmodule

bind mem_backend mem_backend_assert mem_backend_assert_i (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_i),
    .sram_en_i   (sram_req.en),
    .sram_wen_i  (sram_req.wen),
    .stall_i     (stall),
    .issue_cnt_i (mem_req_i.issue_cnt),
    .dc_ram_en_i (dc_to_mem.ram_en),
    .rf_we_i     (rf_we_o),
    .rf_waddr_i  (rf_waddr_o)
);

`default_nettype wire

/* verilog/mem_backend.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_backend #(
    parameter int SRAM_ADDR_W = 10
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush_i,
    input  wire                     stall_req_ex_i,
    input  wire                     stall_req_dc_i,
    input  wire cpu_pkg::ex_to_dc_t ex_bundle_i,
    output logic                    rf_we_o,
    output cpu_pkg::reg_addr_t      rf_waddr_o,
    output cpu_pkg::word_t          rf_wdata_o,
    output cpu_pkg::word_t          wb_pc_o
);

    wire cpu_pkg::stall_t     stall;
    wire cpu_pkg::sram_req_t  sram_req;
    wire cpu_pkg::word_t      sram_rdata;
    wire cpu_pkg::dc_to_mem_t dc_to_mem;
    wire cpu_pkg::mem_to_wb_t mem_to_wb;

    stall_ctrl stall_ctrl_i (
        .stall_req_ex_i (stall_req_ex_i),
        .stall_req_dc_i (stall_req_dc_i),
        .stall_o        (stall)
    );

    mem_req #(
        .SRAM_ADDR_W (SRAM_ADDR_W)
    ) mem_req_i (
        .clk         (clk),
        .rst         (rst),
        .ex_bundle_i (ex_bundle_i),
        .stall_i     (stall),
        .flush_i     (flush_i),
        .sram_req_o  (sram_req)
    );

    data_sram #(
        .SRAM_ADDR_W (SRAM_ADDR_W)
    ) data_sram_i (
        .clk     (clk),
        .req_i   (sram_req),
        .rdata_o (sram_rdata)
    );

    dc dc_i (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .stall_i     (stall),
        .ex_bundle_i (ex_bundle_i),
        .dc_to_mem_o (dc_to_mem)
    );

    mem mem_i (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .stall_i      (stall),
        .dc_to_mem_i  (dc_to_mem),
        .sram_rdata_i (sram_rdata),
        .mem_to_wb_o  (mem_to_wb)
    );

    wb wb_i (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .stall_i     (stall),
        .mem_to_wb_i (mem_to_wb),
        .rf_we_o     (rf_we_o),
        .rf_waddr_o  (rf_waddr_o),
        .rf_wdata_o  (rf_wdata_o),
        .wb_pc_o     (wb_pc_o)
    );

endmodule

`default_nettype wire

/* verilog/wb.sv */
`timescale 1ns/100ps
`default_nettype none

module wb (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flush_i,
    input  wire cpu_pkg::stall_t     stall_i,
    input  wire cpu_pkg::mem_to_wb_t mem_to_wb_i,
    output logic                     rf_we_o,
    output cpu_pkg::reg_addr_t       rf_waddr_o,
    output cpu_pkg::word_t           rf_wdata_o,
    output cpu_pkg::word_t           wb_pc_o
);

    cpu_pkg::mem_to_wb_t wb_in;
    cpu_pkg::mem_to_wb_t wb_q;

    always_comb begin
        wb_in       = mem_to_wb_i;
        wb_in.rf_we = mem_to_wb_i.rf_we && mem_to_wb_i.rf_waddr != 5'd0;  // r0 stays zero
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wb_q <= '0;
        end else if (stall_i[cpu_pkg::STG_MEM] == cpu_pkg::STOP
                     && stall_i[cpu_pkg::STG_WB] == cpu_pkg::NO_STOP) begin
            wb_q <= '0;
        end else if (stall_i[cpu_pkg::STG_MEM] == cpu_pkg::NO_STOP) begin
            wb_q <= wb_in;
        end
    end

    assign rf_we_o    = wb_q.rf_we;
    assign rf_waddr_o = wb_q.rf_waddr;
    assign rf_wdata_o = wb_q.rf_wdata;
    assign wb_pc_o    = wb_q.pc;

endmodule

`default_nettype wire

/* verilog/mem.sv */
`timescale 1ns/100ps
`default_nettype none

module mem (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flush_i,
    input  wire cpu_pkg::stall_t     stall_i,
    input  wire cpu_pkg::dc_to_mem_t dc_to_mem_i,
    input  wire cpu_pkg::word_t      sram_rdata_i,
    output cpu_pkg::mem_to_wb_t      mem_to_wb_o
);

    cpu_pkg::dc_to_mem_t dc_q;
    cpu_pkg::word_t      rdata_q;
    cpu_pkg::word_t      load_result;
    logic [7:0]          ld_byte;
    logic [15:0]         ld_half;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            dc_q <= '0;
        end else if (stall_i[cpu_pkg::STG_DC] == cpu_pkg::STOP
                     && stall_i[cpu_pkg::STG_MEM] == cpu_pkg::NO_STOP) begin
            dc_q <= '0;
        end else if (stall_i[cpu_pkg::STG_DC] == cpu_pkg::NO_STOP) begin
            dc_q <= dc_to_mem_i;
        end
    end

    // Read word travels alongside its instruction
    always_ff @(posedge clk) begin
        if (stall_i[cpu_pkg::STG_DC] == cpu_pkg::NO_STOP) begin
            rdata_q <= sram_rdata_i;
        end
    end

    always_comb begin
        ld_byte = rdata_q[{dc_q.alu_result[1:0], 3'b000} +: 8];
        ld_half = rdata_q[{dc_q.alu_result[1], 4'b0000} +: 16];
        case (dc_q.size)
            cpu_pkg::SIZE_BYTE: begin
                if (dc_q.load_unsigned) begin
                    load_result = {24'b0, ld_byte};
                end else begin
                    load_result = {{24{ld_byte[7]}}, ld_byte};
                end
            end
            cpu_pkg::SIZE_HALF: begin
                if (dc_q.load_unsigned) begin
                    load_result = {16'b0, ld_half};
                end else begin
                    load_result = {{16{ld_half[15]}}, ld_half};
                end
            end
            cpu_pkg::SIZE_WORD: begin
                load_result = rdata_q;
            end
            default: begin
                load_result = rdata_q;
            end
        endcase
    end

    always_comb begin
        mem_to_wb_o.pc       = dc_q.pc;
        mem_to_wb_o.rf_we    = dc_q.rf_we;
        mem_to_wb_o.rf_waddr = dc_q.rf_waddr;
        mem_to_wb_o.rf_wdata = dc_q.sel_rf_res ? load_result : dc_q.alu_result;
    end

endmodule

`default_nettype wire

/* verilog/dc.sv */
`timescale 1ns/100ps
`default_nettype none

module dc (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush_i,
    input  wire cpu_pkg::stall_t    stall_i,
    input  wire cpu_pkg::ex_to_dc_t ex_bundle_i,
    output cpu_pkg::dc_to_mem_t     dc_to_mem_o
);

    cpu_pkg::dc_to_mem_t ex_fields;

    // Store data already went out with the SRAM request
    always_comb begin
        ex_fields.pc            = ex_bundle_i.pc;
        ex_fields.ram_en        = ex_bundle_i.ram_en;
        ex_fields.ram_we        = ex_bundle_i.ram_we;
        ex_fields.size          = ex_bundle_i.size;
        ex_fields.load_unsigned = ex_bundle_i.load_unsigned;
        ex_fields.sel_rf_res    = ex_bundle_i.sel_rf_res;
        ex_fields.rf_we         = ex_bundle_i.rf_we;
        ex_fields.rf_waddr      = ex_bundle_i.rf_waddr;
        ex_fields.alu_result    = ex_bundle_i.alu_result;
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            dc_to_mem_o <= '0;
        end else if (stall_i[cpu_pkg::STG_EX] == cpu_pkg::STOP
                     && stall_i[cpu_pkg::STG_DC] == cpu_pkg::NO_STOP) begin
            dc_to_mem_o <= '0;              // Bubble
        end else if (stall_i[cpu_pkg::STG_EX] == cpu_pkg::NO_STOP) begin
            dc_to_mem_o <= ex_fields;
        end
    end

endmodule

`default_nettype wire

/* verilog/data_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_sram #(
    parameter int SRAM_ADDR_W = 10
) (
    input  wire                     clk,
    input  wire cpu_pkg::sram_req_t req_i,
    output cpu_pkg::word_t          rdata_o
);

    localparam int DEPTH = 2 ** SRAM_ADDR_W;

    cpu_pkg::word_t         ram [DEPTH];
    logic [SRAM_ADDR_W-1:0] word_addr;

    assign word_addr = req_i.addr[SRAM_ADDR_W-1:0];     // Upper bits wrap

    always_ff @(posedge clk) begin
        if (req_i.en) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.wen[b]) begin
                    ram[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
            rdata_o <= ram[word_addr];      // Old word on a same-edge write
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_req.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_req #(
    parameter int SRAM_ADDR_W = 10
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cpu_pkg::ex_to_dc_t ex_bundle_i,
    input  wire cpu_pkg::stall_t    stall_i,
    input  wire                     flush_i,
    output cpu_pkg::sram_req_t      sram_req_o
);

    cpu_pkg::byte_en_t lanes;
    cpu_pkg::word_t    lane_data;
    logic              issue;
    logic [15:0]       issue_cnt;   // Requests issued since reset

    // Issue only on the edge the instruction enters dc
    assign issue = ex_bundle_i.ram_en && !flush_i
                   && stall_i[cpu_pkg::STG_EX] == cpu_pkg::NO_STOP;

    always_comb begin
        case (ex_bundle_i.size)
            cpu_pkg::SIZE_BYTE: begin
                lanes     = 4'b0001 << ex_bundle_i.alu_result[1:0];
                lane_data = {4{ex_bundle_i.store_data[7:0]}};
            end
            cpu_pkg::SIZE_HALF: begin
                lanes     = ex_bundle_i.alu_result[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{ex_bundle_i.store_data[15:0]}};
            end
            cpu_pkg::SIZE_WORD: begin
                lanes     = 4'b1111;
                lane_data = ex_bundle_i.store_data;
            end
            default: begin
                lanes     = 4'b0000;    // Reserved code writes nothing
                lane_data = ex_bundle_i.store_data;
            end
        endcase
    end

    always_comb begin
        sram_req_o.en    = issue;
        sram_req_o.wen   = (issue && ex_bundle_i.ram_we) ? lanes : 4'b0000;
        sram_req_o.addr  = cpu_pkg::word_t'(ex_bundle_i.alu_result[SRAM_ADDR_W+1:2]);
        sram_req_o.wdata = lane_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_cnt <= '0;
        end else if (issue) begin
            issue_cnt <= issue_cnt + 16'd1;
        end
    end

endmodule

`default_nettype wire

/* verilog/stall_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module stall_ctrl (
    input  wire             stall_req_ex_i,
    input  wire             stall_req_dc_i,
    output cpu_pkg::stall_t stall_o
);

    // Deepest requester wins and stops everything upstream of it
    always_comb begin
        stall_o = {7{cpu_pkg::NO_STOP}};
        if (stall_req_dc_i) begin
            stall_o[cpu_pkg::STG_DC:0] = {(cpu_pkg::STG_DC + 1){cpu_pkg::STOP}};
        end else if (stall_req_ex_i) begin
            stall_o[cpu_pkg::STG_EX:0] = {(cpu_pkg::STG_EX + 1){cpu_pkg::STOP}};
        end
    end

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [1:0]  mem_size_t;
    typedef logic [6:0]  stall_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    localparam logic STOP    = 1'b1;
    localparam logic NO_STOP = 1'b0;

    // Bit positions in stall_t, bit 0 is pc
    localparam int STG_EX  = 3;
    localparam int STG_DC  = 4;
    localparam int STG_MEM = 5;
    localparam int STG_WB  = 6;

    typedef struct packed {
        word_t     pc;
        logic      ram_en;
        logic      ram_we;
        mem_size_t size;
        logic      load_unsigned;
        logic      sel_rf_res;      // Load data to register file
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     alu_result;      // Byte address for memory ops
        word_t     store_data;
    } ex_to_dc_t;

    typedef struct packed {
        word_t     pc;
        logic      ram_en;
        logic      ram_we;
        mem_size_t size;
        logic      load_unsigned;
        logic      sel_rf_res;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     alu_result;
    } dc_to_mem_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
    } mem_to_wb_t;

    typedef struct packed {
        logic     en;
        byte_en_t wen;
        word_t    addr;             // Word address
        word_t    wdata;
    } sram_req_t;

endpackage

`default_nettype wire
